// ==== all.f ====
+incdir+logic
logic/nes_loader_pkg.sv
logic/load_count_if.sv
logic/ines_header.sv
logic/load_counter.sv
logic/loader_fsm.sv
logic/nes_game_loader.sv
verif/tb_clock.sv
verif/nes_game_loader_assertions.sv
verif/nes_game_loader_tb.sv

// ==== logic/ines_header.sv ====
//////////////////////////////////////////////////
// iNES header capture
// Stores the 16 header bytes, checks the signature
// and decodes the mapper flag word
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "nes_loader_defs.svh"

module ines_header (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         capture,
	input  logic [7:0]                   indata,
	input  logic                         invert_mirroring,
	output logic                         hdr_last,
	output logic                         hdr_valid,
	output logic [7:0]                   prg_pages,
	output logic [7:0]                   chr_pages,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);

	logic [3:0] byte_idx;
	logic [7:0] hdr [`NES_HDR_BYTES];
	logic       is_nes20;
	logic       is_dirty;

	// Smallest k with pages <= 2**k, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (8'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	//////////////////////////////////////////////////
	// Capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes)
			byte_idx <= 4'd0;
		else if (capture)
			byte_idx <= byte_idx + 4'd1;
	end

	always_ff @(posedge clk) begin
		if (capture)
			hdr[byte_idx] <= indata;
	end

	assign hdr_last = capture && (byte_idx == 4'(`NES_HDR_BYTES - 1));

	// "NES" + EOF, trainers not supported
	assign hdr_valid = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) && (hdr[2] == 8'h53) &&
		(hdr[3] == 8'h1A) && !hdr[6][2];

	assign prg_pages = hdr[4]; // 16 KB units
	assign chr_pages = hdr[5]; // 8 KB units, zero means CHR RAM

	//////////////////////////////////////////////////
	// Flag decode
	//////////////////////////////////////////////////

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Junk in the tail of an old header spoils the upper mapper nibble
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != 7'd0) || (hdr[10] != 8'd0) ||
		(hdr[11] != 8'd0) || (hdr[12] != 8'd0) || (hdr[13] != 8'd0) ||
		(hdr[14] != 8'd0) || (hdr[15] != 8'd0));

	always_comb begin
		mapper_flags.reserved      = 1'b0;
		mapper_flags.piano         = is_nes20 && (hdr[15][5:0] == 6'h19);
		mapper_flags.prg_ram_shift = is_nes20 ? hdr[10][3:0] : 4'd0;
		mapper_flags.has_saves     = hdr[6][1];
		mapper_flags.submapper     = is_nes20 ? hdr[8] : 8'd0;
		mapper_flags.four_screen   = hdr[6][3];
		mapper_flags.has_chr_ram   = (chr_pages == 8'd0);
		mapper_flags.mirroring     = hdr[6][0] ^ invert_mirroring;
		mapper_flags.chr_size      = size_code(chr_pages);
		mapper_flags.prg_size      = size_code(prg_pages);
		mapper_flags.mapper        = {is_dirty ? 4'd0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

// ==== logic/load_count_if.sv ====
//////////////////////////////////////////////////
// Load counter interface
// FSM controls to the counter, status back
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "nes_loader_defs.svh"

interface load_count_if;

	logic                   load_prg; // Start of PRG region
	logic                   load_chr; // Start of CHR region
	logic                   step;     // One byte written
	logic                   count_zero;
	logic [`NES_ADDR_W-1:0] addr;

	modport fsm (output load_prg, output load_chr, output step, input count_zero);

	modport counter (input load_prg, input load_chr, input step, output count_zero,
		output addr);

endinterface

// ==== logic/load_counter.sv ====
//////////////////////////////////////////////////
// Load counter
// Bytes left and write address of the region
// currently being filled
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "nes_loader_defs.svh"

module load_counter (
	input  logic                 clk,
	input  logic                 reset_nes,
	input  logic [7:0]           prg_pages,
	input  logic [7:0]           chr_pages,
	load_count_if.counter        cnt_if
);

	logic [`NES_CNT_W-1:0]  count;
	logic [`NES_ADDR_W-1:0] addr;
	logic [`NES_CNT_W-1:0]  prg_len;
	logic [`NES_CNT_W-1:0]  chr_len;

	// Region lengths in bytes
	assign prg_len = {{(`NES_CNT_W-8){1'b0}}, prg_pages} << `NES_PRG_PAGE_SHIFT;
	assign chr_len = {{(`NES_CNT_W-8){1'b0}}, chr_pages} << `NES_CHR_PAGE_SHIFT;

	//////////////////////////////////////////////////
	// Count and address
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			count <= '0;
			addr  <= '0;
		end else if (cnt_if.load_prg) begin
			count <= prg_len;
			addr  <= `NES_PRG_BASE;
		end else if (cnt_if.load_chr) begin
			count <= chr_len;
			addr  <= `NES_CHR_BASE;
		end else if (cnt_if.step) begin
			count <= count - 1'b1;
			addr  <= addr + 1'b1; // Next byte of the region
		end
	end

	assign cnt_if.count_zero = (count == '0);
	assign cnt_if.addr       = addr;

endmodule

// ==== logic/loader_fsm.sv ====
//////////////////////////////////////////////////
// Loader state machine
// Header, PRG, CHR, then done or error
//////////////////////////////////////////////////

`timescale 1ns/10ps

module loader_fsm (
	input  logic         clk,
	input  logic         reset_nes,
	input  logic         indata_clk,
	input  logic         hdr_last,
	input  logic         hdr_valid,
	output logic         capture,
	output logic         mem_write,
	output logic         busy,
	output logic         done,
	output logic         error,
	load_count_if.fsm    cnt_if
);

	nes_loader_pkg::loader_state_e state;
	logic                          in_payload;
	logic                          write_en;

	//////////////////////////////////////////////////
	// Strobe routing
	//////////////////////////////////////////////////

	assign in_payload = (state == nes_loader_pkg::ST_PRG) ||
		(state == nes_loader_pkg::ST_CHR);

	assign capture  = indata_clk && (state == nes_loader_pkg::ST_HEADER);
	assign write_en = indata_clk && in_payload && !cnt_if.count_zero;

	assign mem_write   = write_en;
	assign cnt_if.step = write_en;

	// Region setup
	assign cnt_if.load_prg = capture && hdr_last && hdr_valid;
	assign cnt_if.load_chr = (state == nes_loader_pkg::ST_PRG) && cnt_if.count_zero;

	//////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= nes_loader_pkg::ST_HEADER;
			busy  <= 1'b0;
			done  <= 1'b0;
			error <= 1'b0;
		end else begin
			case (state)
				nes_loader_pkg::ST_HEADER: begin
					if (capture && hdr_last) begin
						if (hdr_valid) begin
							state <= nes_loader_pkg::ST_PRG;
							busy  <= 1'b1;
						end else begin
							state <= nes_loader_pkg::ST_ERROR;
							done  <= 1'b1;
							error <= 1'b1;
						end
					end
				end
				nes_loader_pkg::ST_PRG: begin
					if (cnt_if.count_zero)
						state <= nes_loader_pkg::ST_CHR; // Counter reloads for CHR
				end
				nes_loader_pkg::ST_CHR: begin
					if (cnt_if.count_zero) begin
						state <= nes_loader_pkg::ST_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
				nes_loader_pkg::ST_DONE: begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				nes_loader_pkg::ST_ERROR: begin
					busy  <= 1'b0;
					done  <= 1'b1;
					error <= 1'b1;
				end
				default: state <= nes_loader_pkg::ST_ERROR;
			endcase
		end
	end

endmodule

// ==== logic/nes_game_loader.sv ====
//////////////////////////////////////////////////
// NES cartridge image loader
// Streams an iNES image into PRG and CHR memory
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "nes_loader_defs.svh"

module nes_game_loader (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic [7:0]             indata,
	input  logic                   indata_clk,
	input  logic                   invert_mirroring,
	output logic [`NES_ADDR_W-1:0] mem_addr,
	output logic [7:0]             mem_data,
	output logic                   mem_write,
	output logic [31:0]            mapper_flags,
	output logic                   busy,
	output logic                   done,
	output logic                   error
);

	logic       capture;
	logic       hdr_last;
	logic       hdr_valid;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;

	load_count_if cnt_if ();

	ines_header ines_header_i (
		.clk(clk), .reset_nes(reset_nes), .capture(capture), .indata(indata),
		.invert_mirroring(invert_mirroring), .hdr_last(hdr_last), .hdr_valid(hdr_valid),
		.prg_pages(prg_pages), .chr_pages(chr_pages), .mapper_flags(mapper_flags)
	);

	load_counter load_counter_i (
		.clk(clk), .reset_nes(reset_nes), .prg_pages(prg_pages),
		.chr_pages(chr_pages), .cnt_if(cnt_if.counter)
	);

	loader_fsm loader_fsm_i (
		.clk(clk), .reset_nes(reset_nes), .indata_clk(indata_clk),
		.hdr_last(hdr_last), .hdr_valid(hdr_valid), .capture(capture),
		.mem_write(mem_write), .busy(busy), .done(done), .error(error),
		.cnt_if(cnt_if.fsm)
	);

	// Payload bytes go straight through
	assign mem_data = indata;
	assign mem_addr = cnt_if.addr;

endmodule

// ==== logic/nes_loader_defs.svh ====
//////////////////////////////////////////////////
// NES cartridge loader constants
// Header length, page sizes, region bases, widths
//////////////////////////////////////////////////

`ifndef NES_LOADER_DEFS_SVH
`define NES_LOADER_DEFS_SVH

// iNES header length in bytes
`define NES_HDR_BYTES 16

// Memory address and byte counter widths
`define NES_ADDR_W 22
`define NES_CNT_W 22

// Page sizes as shift amounts
`define NES_PRG_PAGE_SHIFT 14 // 16 KB PRG page
`define NES_CHR_PAGE_SHIFT 13 // 8 KB CHR page

//////////////////////////////////////////////////
// Region bases in cartridge memory
//////////////////////////////////////////////////

`define NES_PRG_BASE 22'h000000
`define NES_CHR_BASE 22'h200000

`endif

// ==== logic/nes_loader_pkg.sv ====
//////////////////////////////////////////////////
// NES cartridge loader types
// Loader states and the decoded mapper flag word
//////////////////////////////////////////////////

package nes_loader_pkg;

	// Loader sequence
	typedef enum logic [2:0] {
		ST_HEADER = 3'd0, // Collecting the 16 header bytes
		ST_PRG    = 3'd1,
		ST_CHR    = 3'd2,
		ST_DONE   = 3'd3,
		ST_ERROR  = 3'd4  // Bad signature or trainer present
	} loader_state_e;

	// Mapper flag word handed to the rest of the core
	typedef struct packed {
		logic       reserved;      // Always zero
		logic       piano;
		logic [3:0] prg_ram_shift; // NES 2.0 only
		logic       has_saves;
		logic [7:0] submapper;     // NES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the NES loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f all.f \
	--top-module nes_game_loader_tb \
	-Mdir obj_dir -o sim_nes_loader

# The simulator exits non-zero on $fatal; the log decides the result
./obj_dir/sim_nes_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/nes_game_loader_assertions.sv ====
//////////////////////////////////////////////////
// Loader output assertions
// Status and write strobe rules, bound to the top
//////////////////////////////////////////////////

`timescale 1ns/10ps

module nes_game_loader_assertions (
	input logic clk,
	input logic reset_nes,
	input logic mem_write,
	input logic busy,
	input logic done,
	input logic error
);

	// Writes only while loading
	a_write_busy: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> busy) else $error("mem_write seen while busy is low");

	a_error_done: assert property (@(posedge clk) disable iff (reset_nes)
		error |-> done) else $error("error seen without done");

	a_done_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy)) else $error("done and busy both high");

	// Strobes are always separated by idle cycles
	a_write_gap: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |=> !mem_write) else $error("mem_write in two consecutive cycles");

endmodule

bind nes_game_loader nes_game_loader_assertions nes_game_loader_assertions_i (
	.clk(clk), .reset_nes(reset_nes), .mem_write(mem_write), .busy(busy), .done(done),
	.error(error)
);

// ==== verif/nes_game_loader_tb.sv ====
//////////////////////////////////////////////////
// NES cartridge loader testbench
// Streams a table of iNES images and checks the
// writes, the flag word and the status outputs
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "nes_loader_defs.svh"

module nes_game_loader_tb;

	localparam int N_ROWS = 7;
	localparam int N_EXTRA = 4; // Trailing bytes that must not be written

	logic                   clk;
	logic                   por_reset;
	logic                   row_rst;
	logic                   reset_nes;
	logic [7:0]             indata;
	logic                   indata_clk;
	logic                   invert_mirroring;
	logic [`NES_ADDR_W-1:0] mem_addr;
	logic [7:0]             mem_data;
	logic                   mem_write;
	logic [31:0]            mapper_flags;
	logic                   busy;
	logic                   done;
	logic                   error;

	// Stimulus table with header byte 0 in the top byte
	logic [127:0] row_hdr   [N_ROWS];
	logic         row_inv   [N_ROWS];
	logic [31:0]  row_flags [N_ROWS];
	logic         row_err   [N_ROWS];
	int           row_prg   [N_ROWS];
	int           row_chr   [N_ROWS];
	int           num_rows;

	integer seed;
	int     write_count;
	longint limit_ns = 0;

	tb_clock tb_clock_i (.clk(clk), .por_reset(por_reset));

	assign reset_nes = por_reset | row_rst;

	nes_game_loader nes_game_loader_i (
		.clk(clk), .reset_nes(reset_nes), .indata(indata), .indata_clk(indata_clk),
		.invert_mirroring(invert_mirroring), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_write(mem_write), .mapper_flags(mapper_flags), .busy(busy), .done(done),
		.error(error)
	);

	// Writes seen since the last reset
	always @(posedge clk) begin
		if (reset_nes)
			write_count <= 0;
		else if (mem_write)
			write_count <= write_count + 1;
	end

	// Flag word layout from bit 31 down to bit 0
	function automatic logic [31:0] flag_word(input logic piano, input logic [3:0] ram_shift,
		input logic saves, input logic [7:0] submapper, input logic four, input logic chr_ram,
		input logic mirr, input logic [2:0] chr_size, input logic [2:0] prg_size,
		input logic [7:0] mapper);
		return {1'b0, piano, ram_shift, saves, submapper, four, chr_ram, mirr, chr_size,
			prg_size, mapper};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic add_row(input logic [127:0] hdr, input logic inv, input logic [31:0] flags,
		input logic err, input int prg_bytes, input int chr_bytes);
		row_hdr[num_rows]   = hdr;
		row_inv[num_rows]   = inv;
		row_flags[num_rows] = flags;
		row_err[num_rows]   = err;
		row_prg[num_rows]   = prg_bytes;
		row_chr[num_rows]   = chr_bytes;
		num_rows++;
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	task automatic load_table();
		num_rows = 0;
		// iNES 1.0 mapper 1 with 1 PRG and 1 CHR page
		add_row(128'h4E45531A_01011100_00000000_00000000, 1'b0,
			flag_word(0, 4'h0, 0, 8'h00, 0, 0, 1, 3'd0, 3'd0, 8'h01), 1'b0, 16384, 8192);
		// Dirty tail drops the upper mapper nibble
		add_row(128'h4E45531A_00014230_00000000_4469736B, 1'b0,
			flag_word(0, 4'h0, 1, 8'h00, 0, 0, 0, 3'd0, 3'd0, 8'h04), 1'b0, 0, 8192);
		// NES 2.0 with submapper, PRG-RAM shift and piano
		add_row(128'h4E45531A_01000918_25000700_00000019, 1'b0,
			flag_word(1, 4'h7, 0, 8'h25, 1, 1, 1, 3'd0, 3'd0, 8'h10), 1'b0, 16384, 0);
		add_row(128'h4E45531A_00020000_00000000_00000000, 1'b1, // Inverted mirroring
			flag_word(0, 4'h0, 0, 8'h00, 0, 0, 1, 3'd1, 3'd0, 8'h00), 1'b0, 0, 16384);
		// Two PRG pages and CHR RAM
		add_row(128'h4E45531A_02002000_00000000_00000000, 1'b0,
			flag_word(0, 4'h0, 0, 8'h00, 0, 1, 0, 3'd0, 3'd1, 8'h02), 1'b0, 32768, 0);
		add_row(128'h4E454D1A_01010000_00000000_00000000, 1'b0, 32'h0, 1'b1, 0, 0); // Bad sig
		add_row(128'h4E45531A_01010400_00000000_00000000, 1'b0, 32'h0, 1'b1, 0, 0); // Trainer
	endtask

	// One strobe checked mid-cycle and then 2 to 4 idle cycles
	task automatic send_byte(input logic [7:0] b, input logic exp_wr,
		input logic [`NES_ADDR_W-1:0] exp_addr, input logic chk_status, input logic exp_busy);
		int gap;
		gap = 2 + ($unsigned($random(seed)) % 3);
		@(posedge clk);
		indata     <= b;
		indata_clk <= 1'b1;
		@(negedge clk);
		check_value("mem_write", 32'(mem_write), 32'(exp_wr));
		if (exp_wr) begin
			check_value("mem_addr", 32'(mem_addr), 32'(exp_addr));
			check_value("mem_data", 32'(mem_data), 32'(b));
		end
		if (chk_status) begin
			check_value("busy", 32'(busy), 32'(exp_busy));
			check_value("done", 32'(done), 32'h0);
		end
		@(posedge clk);
		indata_clk <= 1'b0;
		repeat (gap - 1) @(posedge clk);
	endtask

	task automatic run_row(input int r);
		int                     total;
		logic [7:0]             b;
		logic [`NES_ADDR_W-1:0] exp_addr;
		total = row_err[r] ? 0 : row_prg[r] + row_chr[r];
		@(posedge clk);
		row_rst          <= 1'b1;
		invert_mirroring <= row_inv[r];
		repeat (3) @(posedge clk);
		row_rst <= 1'b0;
		@(negedge clk);
		check_value("busy", 32'(busy), 32'h0);
		check_value("done", 32'(done), 32'h0);
		check_value("error", 32'(error), 32'h0);
		check_value("mem_write", 32'(mem_write), 32'h0);
		for (int k = 0; k < `NES_HDR_BYTES; k++)
			send_byte(row_hdr[r][127 - 8*k -: 8], 1'b0, '0, 1'b1, 1'b0);
		for (int i = 0; i < total + N_EXTRA; i++) begin
			b = 8'($random(seed));
			if (i < row_prg[r])
				exp_addr = `NES_ADDR_W'(`NES_PRG_BASE + i);
			else
				exp_addr = `NES_ADDR_W'(`NES_CHR_BASE + (i - row_prg[r]));
			send_byte(b, i < total, exp_addr, i < total, 1'b1);
		end
		while (done !== 1'b1) @(posedge clk); // Watchdog bounds this wait
		@(negedge clk);
		check_value("done", 32'(done), 32'h1);
		check_value("busy", 32'(busy), 32'h0);
		check_value("error", 32'(error), 32'(row_err[r]));
		check_value("mapper_flags", mapper_flags, row_flags[r]);
		check_value("write_count", 32'(write_count), 32'(total));
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		longint cycles;
		seed = 70;
		indata           <= 8'h00;
		indata_clk       <= 1'b0;
		invert_mirroring <= 1'b0;
		row_rst          <= 1'b0;
		load_table();
		cycles = 0;
		for (int r = 0; r < num_rows; r++)
			cycles += 16 + N_EXTRA + (row_err[r] ? 0 : row_prg[r] + row_chr[r]);
		limit_ns = cycles * 5 * 10 + 10000; // Worst case 5 cycles per byte
		for (int r = 0; r < num_rows; r++)
			run_row(r);
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("Watchdog expired, the loader never finished its image");
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation timed out");
	end

endmodule

// ==== verif/tb_clock.sv ====
//////////////////////////////////////////////////
// Testbench clock and power-on reset
// 10 ns clock, reset held for the first 3 cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic por_reset
);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	initial begin
		por_reset = 1'b1;
		repeat (3) @(posedge clk);
		por_reset <= 1'b0;
	end

endmodule
